/* hdl/periph_pkg.sv */
// Shared widths, port addresses and the EMS command encoding.
// I/O port addresses compare against the low 16 address bits only.

package periph_pkg;

    localparam int ADDR_W     = 20;
    localparam int DATA_W     = 8;
    localparam int IO_PORT_W  = 16;
    localparam int EMS_SLOTS  = 4;
    localparam int EMS_PAGE_W = 7;

    typedef logic [ADDR_W-1:0]     addr_t;
    typedef logic [DATA_W-1:0]     data_t;
    typedef logic [IO_PORT_W-1:0]  io_port_t;
    typedef logic [EMS_PAGE_W-1:0] ems_page_t;
    typedef logic [1:0]            ems_slot_t;

    // Page command as seen by the EMS write decoder
    typedef struct packed {
        logic      high;
        ems_page_t page;
    } ems_cmd_s;

    // Raw view spots FFh, field view yields the page
    typedef union packed {
        data_t    raw;
        ems_cmd_s cmd;
    } ems_cmd_u;

    // Page number stored when a slot is unmapped
    localparam ems_page_t EMS_PAGE_OFF = 7'h7F;

    localparam io_port_t DEFAULT_EMS_PORT = 16'h0260;
    localparam io_port_t DEFAULT_LPT_PORT = 16'h0378;
    localparam io_port_t DEFAULT_NMI_PORT = 16'h00A0;

endpackage

/* hdl/io_decode.sv */
// I/O page decode, register selects and EMS bank hits.
// Register selects already include AEN and an active I/O strobe.
// EMS_PORT covers four ports, NMI_PORT covers eight.
`timescale 1ns/1ps

module io_decode import periph_pkg::*; #(
    parameter io_port_t EMS_PORT = DEFAULT_EMS_PORT,
    parameter io_port_t LPT_PORT = DEFAULT_LPT_PORT,
    parameter io_port_t NMI_PORT = DEFAULT_NMI_PORT
) (
    input  logic                 clock,
    input  logic                 reset,
    input  addr_t                address_i,
    input  logic                 io_read_n_i,
    input  logic                 io_write_n_i,
    input  logic                 memory_read_n_i,
    input  logic                 address_enable_n_i,
    input  logic                 tandy_video_i,
    input  logic                 ems_enabled_i,
    input  logic [1:0]           ems_window_i,
    input  logic [EMS_SLOTS-1:0] ems_ena_i,
    output logic                 dma_cs_n_o,
    output logic                 dma_page_cs_n_o,
    output logic                 ems_sel_o,
    output logic                 lpt_sel_o,
    output logic                 nmi_sel_o,
    output logic [EMS_SLOTS-1:0] ems_bank_hit_o
);

    logic       iorq;
    logic       io_cycle;
    logic [4:0] io_page;
    logic [3:0] win_base;

    assign iorq     = ~io_read_n_i | ~io_write_n_i;
    assign io_cycle = iorq & ~address_enable_n_i;
    assign io_page  = address_i[9:5];

    // 00h-1Fh DMA controller, 80h-9Fh DMA page register
    assign dma_cs_n_o      = ~(io_cycle && io_page == 5'b00000);
    assign dma_page_cs_n_o = ~(io_cycle && io_page == 5'b00100);

    assign ems_sel_o = io_cycle & ems_enabled_i &
                       (address_i[15:2] == EMS_PORT[15:2]);
    assign lpt_sel_o = io_cycle & (address_i[15:0] == LPT_PORT);
    assign nmi_sel_o = io_cycle & tandy_video_i &
                       (address_i[15:3] == NMI_PORT[15:3]);

    always_comb begin
        case (ems_window_i)
            2'd0:    win_base = 4'hA;
            2'd1:    win_base = 4'hC;
            default: win_base = 4'hD;
        endcase
    end

    // 16 KB banks, slot number in address bits 15:14
    always_comb begin
        for (int k = 0; k < EMS_SLOTS; k++) begin
            ems_bank_hit_o[k] = ~iorq & ems_ena_i[k] &
                                (address_i[19:14] == {win_base, ems_slot_t'(k)});
        end
    end

    // Port parameters must not overlap
    a_sel_onehot: assert property (@(posedge clock) disable iff (reset)
        $onehot0({ems_sel_o, lpt_sel_o, nmi_sel_o}))
        else $error("register selects overlap");

    // Bank hits rely on the CPU never mixing memory and I/O strobes
    a_mem_io_excl: assert property (@(posedge clock) disable iff (reset)
        ~memory_read_n_i |-> ~iorq)
        else $error("memory read during I/O strobe");

endmodule

/* hdl/ems_mapper.sv */
// Four-slot EMS page map behind ports 260h-263h.
// A write is staged on the first edge and committed on the second,
// so a read of the same slot sees it two cycles after the write.
`timescale 1ns/1ps

module ems_mapper import periph_pkg::*; (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 ems_sel_i,
    input  logic                 io_write_n_i,
    input  ems_slot_t            slot_i,
    input  data_t                data_i,
    output ems_page_t            ems_map_o [0:EMS_SLOTS-1],
    output logic [EMS_SLOTS-1:0] ems_ena_o,
    output data_t                ems_rdata_o
);

    ems_cmd_u  cmd;
    logic      cmd_off;
    logic      cmd_map;
    logic      wr_pending;
    ems_slot_t wr_slot;
    ems_page_t wr_page;
    logic      wr_ena;

    assign cmd     = ems_cmd_u'(data_i);
    assign cmd_off = (cmd.raw == 8'hFF);
    assign cmd_map = ~cmd.cmd.high;

    // Bytes 80h-FEh are ignored and never staged
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            wr_pending <= 1'b0;
        end else begin
            wr_pending <= ems_sel_i & ~io_write_n_i & (cmd_off | cmd_map);
        end
    end

    always_ff @(posedge clock) begin
        wr_slot <= slot_i;
        wr_page <= cmd_off ? EMS_PAGE_OFF : cmd.cmd.page;
        wr_ena  <= ~cmd_off;
    end

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            for (int i = 0; i < EMS_SLOTS; i++) begin
                ems_map_o[i] <= '0;
            end
            ems_ena_o <= '0;
        end else if (wr_pending) begin
            ems_map_o[wr_slot] <= wr_page;
            ems_ena_o[wr_slot] <= wr_ena;
        end
    end

    // Unmapped slots read back as FFh
    assign ems_rdata_o = ems_ena_o[slot_i] ? {1'b0, ems_map_o[slot_i]} : 8'hFF;

    a_slot_range: assert property (@(posedge clock) disable iff (reset)
        wr_pending |-> int'(wr_slot) < EMS_SLOTS)
        else $error("staged EMS slot out of range");

endmodule

/* hdl/io_latches.sv */
// Printer data and NMI mask byte latches, both reset to FFh.
// Writes land on the strobe edge and read back from the next cycle.
`timescale 1ns/1ps

module io_latches import periph_pkg::*; (
    input  logic  clock,
    input  logic  reset,
    input  logic  lpt_sel_i,
    input  logic  nmi_sel_i,
    input  logic  io_write_n_i,
    input  data_t data_i,
    output data_t lpt_data_o,
    output data_t nmi_mask_o
);

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            lpt_data_o <= 8'hFF;
        end else if (lpt_sel_i && !io_write_n_i) begin
            lpt_data_o <= data_i;
        end
    end

    // Only reachable in Tandy mode, the decoder gates the select
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            nmi_mask_o <= 8'hFF;
        end else if (nmi_sel_i && !io_write_n_i) begin
            nmi_mask_o <= data_i;
        end
    end

endmodule

/* hdl/read_mux.sv */
// Registered read-data stage, one cycle after the read strobe.
// Priority is EMS, then LPT, then NMI mask.
// Outputs zero with the valid flag low when no register claims the read.
`timescale 1ns/1ps

module read_mux import periph_pkg::*; (
    input  logic  clock,
    input  logic  reset,
    input  logic  io_read_n_i,
    input  logic  ems_sel_i,
    input  logic  lpt_sel_i,
    input  logic  nmi_sel_i,
    input  data_t ems_rdata_i,
    input  data_t lpt_data_i,
    input  data_t nmi_mask_i,
    output data_t rdata_o,
    output logic  rdata_valid_o
);

    logic rd;

    assign rd = ~io_read_n_i;

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            rdata_valid_o <= 1'b0;
            rdata_o       <= '0;
        end else if (rd && ems_sel_i) begin
            rdata_valid_o <= 1'b1;
            rdata_o       <= ems_rdata_i;
        end else if (rd && lpt_sel_i) begin
            rdata_valid_o <= 1'b1;
            rdata_o       <= lpt_data_i;
        end else if (rd && nmi_sel_i) begin
            rdata_valid_o <= 1'b1;
            rdata_o       <= nmi_mask_i;
        end else begin
            rdata_valid_o <= 1'b0;
            rdata_o       <= '0;
        end
    end

    a_valid_src: assert property (@(posedge clock) disable iff (reset)
        rdata_valid_o |-> $past(rd && (ems_sel_i || lpt_sel_i || nmi_sel_i)))
        else $error("read data valid without a claimed read");

endmodule

/* hdl/periph_top.sv */
// XT peripheral I/O side: DMA selects, EMS page map, LPT and NMI latches.
// All inputs are sampled on clock, no wait states are inserted.
// NMI mask port exists only while tandy_video_i is high.
`timescale 1ns/1ps

module periph_top import periph_pkg::*; #(
    parameter io_port_t EMS_PORT = DEFAULT_EMS_PORT,
    parameter io_port_t LPT_PORT = DEFAULT_LPT_PORT,
    parameter io_port_t NMI_PORT = DEFAULT_NMI_PORT
) (
    input  logic                 clock,
    input  logic                 reset,
    input  addr_t                address_i,
    input  data_t                data_i,
    input  logic                 io_read_n_i,
    input  logic                 io_write_n_i,
    input  logic                 memory_read_n_i,
    input  logic                 address_enable_n_i,
    input  logic                 tandy_video_i,
    input  logic                 ems_enabled_i,
    input  logic [1:0]           ems_window_i,
    output logic                 dma_cs_n_o,
    output logic                 dma_page_cs_n_o,
    output logic [EMS_SLOTS-1:0] ems_bank_hit_o,
    output ems_page_t            ems_map_o [0:EMS_SLOTS-1],
    output logic [EMS_SLOTS-1:0] ems_ena_o,
    output data_t                rdata_o,
    output logic                 rdata_valid_o
);

    logic  ems_sel;
    logic  lpt_sel;
    logic  nmi_sel;
    data_t ems_rdata;
    data_t lpt_data;
    data_t nmi_mask;

    io_decode #(
        .EMS_PORT (EMS_PORT),
        .LPT_PORT (LPT_PORT),
        .NMI_PORT (NMI_PORT)
    ) u_io_decode (
        .clock              (clock),
        .reset              (reset),
        .address_i          (address_i),
        .io_read_n_i        (io_read_n_i),
        .io_write_n_i       (io_write_n_i),
        .memory_read_n_i    (memory_read_n_i),
        .address_enable_n_i (address_enable_n_i),
        .tandy_video_i      (tandy_video_i),
        .ems_enabled_i      (ems_enabled_i),
        .ems_window_i       (ems_window_i),
        .ems_ena_i          (ems_ena_o),
        .dma_cs_n_o         (dma_cs_n_o),
        .dma_page_cs_n_o    (dma_page_cs_n_o),
        .ems_sel_o          (ems_sel),
        .lpt_sel_o          (lpt_sel),
        .nmi_sel_o          (nmi_sel),
        .ems_bank_hit_o     (ems_bank_hit_o)
    );

    ems_mapper u_ems_mapper (
        .clock        (clock),
        .reset        (reset),
        .ems_sel_i    (ems_sel),
        .io_write_n_i (io_write_n_i),
        .slot_i       (address_i[1:0]),
        .data_i       (data_i),
        .ems_map_o    (ems_map_o),
        .ems_ena_o    (ems_ena_o),
        .ems_rdata_o  (ems_rdata)
    );

    io_latches u_io_latches (
        .clock        (clock),
        .reset        (reset),
        .lpt_sel_i    (lpt_sel),
        .nmi_sel_i    (nmi_sel),
        .io_write_n_i (io_write_n_i),
        .data_i       (data_i),
        .lpt_data_o   (lpt_data),
        .nmi_mask_o   (nmi_mask)
    );

    read_mux u_read_mux (
        .clock         (clock),
        .reset         (reset),
        .io_read_n_i   (io_read_n_i),
        .ems_sel_i     (ems_sel),
        .lpt_sel_i     (lpt_sel),
        .nmi_sel_i     (nmi_sel),
        .ems_rdata_i   (ems_rdata),
        .lpt_data_i    (lpt_data),
        .nmi_mask_i    (nmi_mask),
        .rdata_o       (rdata_o),
        .rdata_valid_o (rdata_valid_o)
    );

endmodule

/* tb/periph_tb.sv */
// Replays bus operations from tb/periph_vectors.txt against periph_top.
// Each operation takes one cycle plus two idle cycles unless the vector
// asks for a back-to-back follower. The vector list ends with op F.
`timescale 1ns/1ps

module periph_tb import periph_pkg::*; ();

    localparam int CLK_PERIOD    = 4;
    localparam int RESET_CYCLES  = 3;
    localparam int FIELDS        = 6;
    localparam int MAX_VEC       = 64;
    localparam int MARGIN_CYCLES = 20;

    localparam logic [19:0] OP_WRITE = 20'h0;
    localparam logic [19:0] OP_READ  = 20'h1;
    localparam logic [19:0] OP_PROBE = 20'h2;
    localparam logic [19:0] OP_END   = 20'hF;
    localparam logic [19:0] NO_CLAIM = 20'h100;

    logic                 clock;
    logic                 reset;
    addr_t                address;
    data_t                data;
    logic                 io_read_n;
    logic                 io_write_n;
    logic                 memory_read_n;
    logic                 address_enable_n;
    logic                 tandy_video;
    logic                 ems_enabled;
    logic [1:0]           ems_window;
    logic                 dma_cs_n;
    logic                 dma_page_cs_n;
    logic [EMS_SLOTS-1:0] ems_bank_hit;
    ems_page_t            ems_map [0:EMS_SLOTS-1];
    logic [EMS_SLOTS-1:0] ems_ena;
    data_t                rdata;
    logic                 rdata_valid;

    logic [19:0] vec_mem [0:MAX_VEC*FIELDS-1];
    int          num_vec;
    int          errors;
    int          checks;
    int          timeout_ns;
    bit          vectors_loaded;

    periph_top u_periph_top (
        .clock              (clock),
        .reset              (reset),
        .address_i          (address),
        .data_i             (data),
        .io_read_n_i        (io_read_n),
        .io_write_n_i       (io_write_n),
        .memory_read_n_i    (memory_read_n),
        .address_enable_n_i (address_enable_n),
        .tandy_video_i      (tandy_video),
        .ems_enabled_i      (ems_enabled),
        .ems_window_i       (ems_window),
        .dma_cs_n_o         (dma_cs_n),
        .dma_page_cs_n_o    (dma_page_cs_n),
        .ems_bank_hit_o     (ems_bank_hit),
        .ems_map_o          (ems_map),
        .ems_ena_o          (ems_ena),
        .rdata_o            (rdata),
        .rdata_valid_o      (rdata_valid)
    );

    always #(CLK_PERIOD / 2) clock = ~clock;

    function automatic string op_name(input logic [19:0] op);
        case (op)
            OP_WRITE: return "write";
            OP_READ:  return "read";
            OP_PROBE: return "probe";
            default:  return "unknown";
        endcase
    endfunction

    task automatic drive_idle();
        address          = '0;
        data             = '0;
        io_read_n        = 1'b1;
        io_write_n       = 1'b1;
        memory_read_n    = 1'b1;
        address_enable_n = 1'b1;
    endtask

    // Map and enable outputs for the slot that an EMS read returned
    task automatic check_ems_map(input string name, input ems_slot_t slot, input data_t exp);
        logic exp_ena;
        exp_ena = (exp != 8'hFF);
        checks++;
        if (ems_ena[slot] != exp_ena) begin
            errors++;
            $display("[ERROR] %s enable: expected %b, actual %b", name, exp_ena,
                     ems_ena[slot]);
        end else if (exp_ena && ems_map[slot] != exp[6:0]) begin
            errors++;
            $display("[ERROR] %s map: expected %h, actual %h", name, exp[6:0],
                     ems_map[slot]);
        end
    endtask

    // Entered and left 1 ns after a rising edge
    task automatic run_vector(input int idx);
        logic [19:0] op;
        logic [19:0] addr;
        logic [19:0] wdata;
        logic [19:0] win;
        logic [19:0] ctrl;
        logic [19:0] exp;
        logic        dma_exp_n;
        logic        page_exp_n;
        logic        is_ems;
        string       name;
        op    = vec_mem[idx*FIELDS];
        addr  = vec_mem[idx*FIELDS+1];
        wdata = vec_mem[idx*FIELDS+2];
        win   = vec_mem[idx*FIELDS+3];
        ctrl  = vec_mem[idx*FIELDS+4];
        exp   = vec_mem[idx*FIELDS+5];
        name  = $sformatf("vec%0d %s %05h", idx, op_name(op), addr);
        // DMA controller at 00h-1Fh, page register at 80h-9Fh
        dma_exp_n  = !(op != OP_PROBE && addr[9:0] < 10'h020);
        page_exp_n = !(op != OP_PROBE && addr[9:0] >= 10'h080 && addr[9:0] < 10'h0A0);
        is_ems     = ctrl[1] && addr[15:0] >= DEFAULT_EMS_PORT &&
                     addr[15:0] < DEFAULT_EMS_PORT + 16'd4;
        address     = addr;
        data        = wdata[7:0];
        ems_window  = win[1:0];
        tandy_video = ctrl[0];
        ems_enabled = ctrl[1];
        if (op == OP_PROBE) begin
            memory_read_n = 1'b0;
        end else begin
            address_enable_n = 1'b0;
            if (op == OP_WRITE) begin
                io_write_n = 1'b0;
            end else begin
                io_read_n = 1'b0;
            end
        end
        // Selects and bank hits are combinational
        #1;
        checks++;
        if (dma_cs_n != dma_exp_n || dma_page_cs_n != page_exp_n) begin
            errors++;
            $display("[ERROR] %s dma selects: expected %b%b, actual %b%b", name,
                     dma_exp_n, page_exp_n, dma_cs_n, dma_page_cs_n);
        end
        if (op == OP_PROBE) begin
            checks++;
            if (ems_bank_hit != exp[3:0]) begin
                errors++;
                $display("[ERROR] %s: expected %h, actual %h", name, exp[3:0], ems_bank_hit);
            end
        end
        @(posedge clock);
        #1;
        if (op == OP_READ) begin
            checks++;
            if (exp == NO_CLAIM) begin
                if (rdata_valid) begin
                    errors++;
                    $display("%s: read was claimed although no register should answer", name);
                end else if (rdata != 8'h00) begin
                    errors++;
                    $display("[ERROR] %s: expected %h, actual %h", name, 8'h00, rdata);
                end
            end else if (!rdata_valid) begin
                errors++;
                $display("%s: read data came back without the valid flag", name);
            end else if (rdata != exp[7:0]) begin
                errors++;
                $display("[ERROR] %s: expected %h, actual %h", name, exp[7:0], rdata);
            end
            if (exp != NO_CLAIM && is_ems) begin
                check_ems_map(name, addr[1:0], exp[7:0]);
            end
        end
        drive_idle();
        if (!ctrl[2]) begin
            repeat (2) @(posedge clock);
            #1;
        end
    endtask

    initial begin
        clock       = 1'b0;
        reset       = 1'b1;
        tandy_video = 1'b0;
        ems_enabled = 1'b0;
        ems_window  = 2'd0;
        drive_idle();
        errors  = 0;
        checks  = 0;
        num_vec = 0;
        $readmemh("tb/periph_vectors.txt", vec_mem);
        while (num_vec < MAX_VEC && vec_mem[num_vec*FIELDS] != OP_END) begin
            num_vec++;
        end
        vectors_loaded = 1'b1;
        repeat (RESET_CYCLES) @(posedge clock);
        #1;
        reset = 1'b0;
        if (num_vec == 0) begin
            errors++;
            $display("No vectors were found in the stimulus file");
        end
        for (int i = 0; i < num_vec; i++) begin
            run_vector(i);
        end
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // Three cycles per vector plus reset and some slack
    initial begin
        wait (vectors_loaded);
        timeout_ns = (num_vec * 3 + RESET_CYCLES + MARGIN_CYCLES) * CLK_PERIOD;
        #(timeout_ns);
        $display("Timeout after %0d ns, vector replay did not finish", timeout_ns);
        $display("TEST FAILED");
        $finish;
    end

endmodule

/* tb/periph_vectors.txt */
// op addr data window ctrl expect, all hex; op 0 write, 1 read, 2 probe, F end
// ctrl bit0 tandy, bit1 ems enabled, bit2 next op back-to-back; expect 100 = no claim
// After reset
1 00378 00 0 2 0FF
1 00260 00 0 2 0FF
2 A8000 00 0 2 000
2 C4000 00 1 2 000
// Printer latch
0 00378 5A 0 2 000
1 00378 00 0 2 05A
// NMI mask in Tandy mode, then hidden
0 000A3 3C 0 3 000
1 000A3 00 0 3 03C
1 000A0 00 0 3 03C
1 000A3 00 0 2 100
// EMS write rule on slot 1
0 00261 12 0 2 000
1 00261 00 0 2 012
0 00261 90 0 2 000
1 00261 00 0 2 012
0 00261 FF 0 2 000
1 00261 00 0 2 0FF
// Bank hits with slot 2 mapped
0 00262 05 0 2 000
2 A8000 00 0 2 004
2 A8000 00 1 2 000
2 C8000 00 1 2 004
2 D8000 00 2 2 004
2 D8000 00 3 2 004
// EMS ports off
1 00262 00 0 0 100
0 00262 33 0 0 000
1 00262 00 0 2 005
// Back-to-back writes to slots 0 and 3
0 00260 21 0 6 000
0 00263 47 0 2 000
1 00260 00 0 2 021
1 00263 00 0 2 047
2 AC000 00 0 2 008
F 00000 00 0 0 000

/* all.f */
hdl/periph_pkg.sv
hdl/io_decode.sv
hdl/ems_mapper.sv
hdl/io_latches.sv
hdl/read_mux.sv
hdl/periph_top.sv
tb/periph_tb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --assert --top-module periph_tb -f all.f -o periph_sim &&
./obj_dir/periph_sim | tee /dev/stderr | grep -q "TEST OK" &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }
